// File: verilog/dram_pkg.sv
/* shared widths and request types for the dram model
   channel address is one data word, mapped row, bank, column from msb to lsb */
package dram_pkg;

  // channel word address
  localparam int ch_addr_width = 10;

  // address fields, column in the low bits
  localparam int col_width = 4;
  localparam int bank_width = 2;
  localparam int row_width = 4;

  localparam int num_banks = 1 << bank_width;

  // data word
  localparam int data_width = 32;

  typedef logic [ch_addr_width-1:0] ch_addr_t;
  typedef logic [data_width-1:0] data_t;
  typedef logic [row_width-1:0] row_t;
  typedef logic [bank_width-1:0] bank_t;
  typedef logic [col_width-1:0] col_t;

  // request as presented by the requester
  typedef struct packed {
    logic write_not_read;
    ch_addr_t addr;
  } dram_req_s;

  // read completion from the timer to the store
  typedef struct packed {
    logic valid;
    ch_addr_t addr;
  } read_done_s;

endpackage

// File: verilog/dram_bank_timer.sv
/* lat_hit_p must be at least 1 and no larger than lat_miss_p
   reads retire strictly in order, so a slow head delays every later read */
module dram_bank_timer
  #(parameter int queue_depth_p = 4
    , parameter int lat_hit_p = 6
    , parameter int lat_miss_p = 14
  )
  (
    input clk_i
    , input reset_i

    , input logic accept_i
    , input dram_pkg::dram_req_s req_i

    , output logic space_o
    , output dram_pkg::read_done_s done_o
  );

  import dram_pkg::*;

  localparam int ptr_width_lp = (queue_depth_p > 1) ? $clog2(queue_depth_p) : 1;
  localparam int cnt_width_lp = $clog2(queue_depth_p + 1);
  localparam int lat_width_lp = $clog2(lat_miss_p + 1);

  typedef logic [ptr_width_lp-1:0] ptr_t;
  typedef logic [cnt_width_lp-1:0] cnt_t;
  typedef logic [lat_width_lp-1:0] lat_t;

  // accept cycle counts as the first cycle of latency
  localparam lat_t hit_load_lp = lat_t'(lat_hit_p - 1);
  localparam lat_t miss_load_lp = lat_t'(lat_miss_p - 1);

  localparam ptr_t last_ptr_lp = ptr_t'(queue_depth_p - 1);
  localparam cnt_t full_cnt_lp = cnt_t'(queue_depth_p);

  // fixed row-bank-column map
  typedef struct packed {
    row_t row;
    bank_t bank;
    col_t col;
  } addr_fields_s;

  addr_fields_s req_fields;
  assign req_fields = req_i.addr;

  // open row per bank
  row_t open_row_r [num_banks];
  logic [num_banks-1:0] open_v_r;

  logic row_hit;
  lat_t load_lat;

  assign row_hit = open_v_r[req_fields.bank]
                   & (open_row_r[req_fields.bank] == req_fields.row);
  assign load_lat = row_hit ? hit_load_lp : miss_load_lp;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      open_v_r <= '0;
    end else if (accept_i) begin
      open_v_r[req_fields.bank] <= 1'b1;
    end
  end

  // writes open their row too
  always_ff @(posedge clk_i) begin
    if (accept_i) begin
      open_row_r[req_fields.bank] <= req_fields.row;
    end
  end

  // pending reads, oldest at head
  ch_addr_t q_addr_r [queue_depth_p];
  lat_t q_lat_r [queue_depth_p];
  ptr_t head_r;
  ptr_t tail_r;
  cnt_t count_r;

  logic push;
  logic pop;

  function automatic ptr_t next_ptr(input ptr_t p);
    if (p == last_ptr_lp) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign push = accept_i & ~req_i.write_not_read;
  assign pop = (count_r != '0) & (q_lat_r[head_r] == '0);

  assign space_o = (count_r != full_cnt_lp);
  assign done_o.valid = pop;
  assign done_o.addr = q_addr_r[head_r];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      head_r <= '0;
      tail_r <= '0;
      count_r <= '0;
    end else begin
      if (push) begin
        tail_r <= next_ptr(tail_r);
      end
      if (pop) begin
        head_r <= next_ptr(head_r);
      end
      case ({push, pop})
        2'b10: count_r <= count_r + 1'b1;
        2'b01: count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // all entries count down together and stop at zero
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < queue_depth_p; i++) begin
      if (push && (tail_r == ptr_t'(i))) begin
        q_addr_r[i] <= req_i.addr;
        q_lat_r[i] <= load_lat;
      end else if (q_lat_r[i] != '0) begin
        q_lat_r[i] <= q_lat_r[i] - 1'b1;
      end
    end
  end

endmodule

// File: verilog/dram_channel_store.sv
/* contents start at zero and survive reset
   a read completing in the same cycle as a write to its address returns the old word */
module dram_channel_store
  (
    input clk_i
    , input reset_i

    , input logic write_v_i
    , input dram_pkg::ch_addr_t write_addr_i
    , input dram_pkg::data_t data_i

    , input dram_pkg::read_done_s done_i

    , output logic data_v_o
    , output dram_pkg::data_t data_o
  );

  import dram_pkg::*;

  // one word per channel address
  localparam int mem_els_lp = 1 << ch_addr_width;

  data_t mem_r [mem_els_lp] = '{default: '0};

  always_ff @(posedge clk_i) begin
    if (write_v_i) begin
      mem_r[write_addr_i] <= data_i;
    end
  end

  // read word lands one cycle after the completion
  always_ff @(posedge clk_i) begin
    if (done_i.valid) begin
      data_o <= mem_r[done_i.addr];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      data_v_o <= 1'b0;
    end else begin
      data_v_o <= done_i.valid;
    end
  end

endmodule

// File: verilog/dram_model.sv
/* requests are taken on the rising edge; the requester holds v_i and req_i until yumi_o
   reads stall while the channel queue is full, writes wait only for data_v_i */
module dram_model
  #(parameter int num_channels_p = 2
    , parameter int queue_depth_p = 4
    , parameter int lat_hit_p = 6
    , parameter int lat_miss_p = 14
  )
  (
    input clk_i
    , input reset_i

    , input [num_channels_p-1:0] v_i
    , input dram_pkg::dram_req_s [num_channels_p-1:0] req_i
    , output logic [num_channels_p-1:0] yumi_o

    , input [num_channels_p-1:0] data_v_i
    , input dram_pkg::data_t [num_channels_p-1:0] data_i
    , output logic [num_channels_p-1:0] data_yumi_o

    , output logic [num_channels_p-1:0] data_v_o
    , output dram_pkg::data_t [num_channels_p-1:0] data_o
  );

  import dram_pkg::*;

  logic [num_channels_p-1:0] space;
  logic [num_channels_p-1:0] accept;
  logic [num_channels_p-1:0] write_v;
  read_done_s [num_channels_p-1:0] read_done;

  for (genvar i = 0; i < num_channels_p; i++) begin : ch

    // write needs its data now, read needs a queue slot
    assign accept[i] = v_i[i] & (req_i[i].write_not_read ? data_v_i[i] : space[i]);
    assign write_v[i] = accept[i] & req_i[i].write_not_read;

    assign yumi_o[i] = accept[i];
    assign data_yumi_o[i] = write_v[i];

    dram_bank_timer
      #(.queue_depth_p(queue_depth_p)
        ,.lat_hit_p(lat_hit_p)
        ,.lat_miss_p(lat_miss_p))
    timer
      (.clk_i(clk_i)
      ,.reset_i(reset_i)

      ,.accept_i(accept[i])
      ,.req_i(req_i[i])

      ,.space_o(space[i])
      ,.done_o(read_done[i])
    );

    dram_channel_store
    store
      (.clk_i(clk_i)
      ,.reset_i(reset_i)

      ,.write_v_i(write_v[i])
      ,.write_addr_i(req_i[i].addr)
      ,.data_i(data_i[i])

      ,.done_i(read_done[i])

      ,.data_v_o(data_v_o[i])
      ,.data_o(data_o[i])
    );

  end

endmodule

// File: bench/dram_model_checker.sv
/* watches the dram model ports at the rising edge and predicts data, order and return cycle
   assumes one reset at the start, with all rows closed and zero memory contents */
module dram_model_checker
  #(parameter int num_channels_p = 2
    , parameter int queue_depth_p = 4
    , parameter int lat_hit_p = 6
    , parameter int lat_miss_p = 14
  )
  (
    input clk_i
    , input reset_i
    , input [num_channels_p-1:0] v_i
    , input dram_pkg::dram_req_s [num_channels_p-1:0] req_i
    , input [num_channels_p-1:0] wdata_v_i
    , input dram_pkg::data_t [num_channels_p-1:0] wdata_i
    , input [num_channels_p-1:0] yumi_i
    , input [num_channels_p-1:0] data_yumi_i
    , input [num_channels_p-1:0] rdata_v_i
    , input dram_pkg::data_t [num_channels_p-1:0] rdata_i
    , output int error_count_o
    , output int pending_o
    , output int reads_o
    , output int writes_o
  );

  timeunit 1ns;
  timeprecision 100ps;

  import dram_pkg::*;

  localparam int mem_els_lp = 1 << ch_addr_width;
  localparam int buf_els_lp = 64;

  data_t ref_mem [num_channels_p][mem_els_lp];
  logic pw_v [num_channels_p];
  ch_addr_t pw_addr [num_channels_p];
  data_t pw_data [num_channels_p];

  logic open_v [num_channels_p][num_banks];
  row_t open_row [num_channels_p][num_banks];

  // expected reads in accept order
  ch_addr_t exp_addr [num_channels_p][buf_els_lp];
  int exp_done [num_channels_p][buf_els_lp];
  int head [num_channels_p];
  int count [num_channels_p];
  int last_done [num_channels_p];
  int edge_n = 0;

  initial begin
    error_count_o = 0;
    pending_o = 0;
    reads_o = 0;
    writes_o = 0;
    for (int ch = 0; ch < num_channels_p; ch++) begin
      for (int a = 0; a < mem_els_lp; a++) begin
        ref_mem[ch][a] = '0;
      end
    end
  end

  function automatic int read_latency(input logic was_open, input row_t open_r, input row_t row);
    if (was_open && (open_r == row)) begin
      return lat_hit_p;
    end
    return lat_miss_p;
  endfunction

  // completion cycle, never before or with the read ahead of it
  function automatic int done_edge(input int accept_edge, input int lat, input int prev_done);
    if (accept_edge + lat > prev_done) begin
      return accept_edge + lat;
    end
    return prev_done + 1;
  endfunction

  task automatic check_channel(input int ch);
    int slot;
    data_t exp_word;
    logic is_write;
    logic exp_yumi;
    bank_t bank;
    row_t row;
    is_write = req_i[ch].write_not_read;
    bank = req_i[ch].addr[col_width +: bank_width];
    row = req_i[ch].addr[col_width + bank_width +: row_width];
    slot = head[ch];
    if (rdata_v_i[ch]) begin
      if (count[ch] == 0) begin
        $display("channel %0d returned read data with no read outstanding", ch);
        error_count_o++;
      end else begin
        exp_word = ref_mem[ch][exp_addr[ch][slot]];
        if (rdata_i[ch] !== exp_word) begin
          $display("Mismatch data_o ch=%0d exp=%h got=%h", ch, exp_word, rdata_i[ch]);
          error_count_o++;
        end
        if (edge_n != exp_done[ch][slot] + 1) begin
          $display("channel %0d read of %h returned in cycle %0d instead of %0d",
                   ch, exp_addr[ch][slot], edge_n, exp_done[ch][slot] + 1);
          error_count_o++;
        end
        head[ch] = (head[ch] + 1) % buf_els_lp;
        count[ch]--;
        pending_o--;
        reads_o++;
      end
    end else if (count[ch] != 0 && edge_n == exp_done[ch][slot] + 1) begin
      $display("channel %0d read of %h did not return in cycle %0d",
               ch, exp_addr[ch][slot], edge_n);
      error_count_o++;
    end
    // completion returns the old word, so last cycle's write lands after the compare
    if (pw_v[ch]) begin
      ref_mem[ch][pw_addr[ch]] = pw_data[ch];
      pw_v[ch] = 1'b0;
    end
    exp_yumi = v_i[ch] & (is_write ? wdata_v_i[ch] : (count[ch] < queue_depth_p));
    if (yumi_i[ch] !== exp_yumi) begin
      $display("Mismatch yumi_o ch=%0d exp=%h got=%h", ch, exp_yumi, yumi_i[ch]);
      error_count_o++;
    end
    if (data_yumi_i[ch] !== (exp_yumi & is_write)) begin
      $display("Mismatch data_yumi_o ch=%0d exp=%h got=%h",
               ch, exp_yumi & is_write, data_yumi_i[ch]);
      error_count_o++;
    end
    if (yumi_i[ch]) begin
      if (is_write) begin
        pw_v[ch] = 1'b1;
        pw_addr[ch] = req_i[ch].addr;
        pw_data[ch] = wdata_i[ch];
        writes_o++;
      end else if (count[ch] >= buf_els_lp) begin
        $display("channel %0d accepted more reads than can be outstanding", ch);
        error_count_o++;
      end else begin
        slot = (head[ch] + count[ch]) % buf_els_lp;
        exp_addr[ch][slot] = req_i[ch].addr;
        exp_done[ch][slot] = done_edge(edge_n,
          read_latency(open_v[ch][bank], open_row[ch][bank], row), last_done[ch]);
        last_done[ch] = exp_done[ch][slot];
        count[ch]++;
        pending_o++;
      end
      open_v[ch][bank] = 1'b1;
      open_row[ch][bank] = row;
    end
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      edge_n = 0;
      for (int ch = 0; ch < num_channels_p; ch++) begin
        for (int b = 0; b < num_banks; b++) begin
          open_v[ch][b] = 1'b0;
        end
        head[ch] = 0;
        count[ch] = 0;
        last_done[ch] = -1000;
        pw_v[ch] = 1'b0;
      end
    end else begin
      edge_n++;
      for (int ch = 0; ch < num_channels_p; ch++) begin
        check_channel(ch);
      end
    end
  end

endmodule

// File: bench/dram_model_tb.sv
/* random traffic on both channels from a fixed-seed LCG, inputs change on the falling edge
   the run ends once every request is accepted and every read has returned, or at the timeout */
module dram_model_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import dram_pkg::*;

  localparam int num_channels_lp = 2;
  localparam int queue_depth_lp = 4;
  localparam int lat_hit_lp = 6;
  localparam int lat_miss_lp = 14;

  localparam int reqs_per_ch_lp = 200;
  localparam int total_reqs_lp = reqs_per_ch_lp * num_channels_lp;
  localparam int timeout_lp = total_reqs_lp * (lat_miss_lp + 1) * queue_depth_lp + 1000;

  logic clk = 1'b0;
  logic reset = 1'b1;
  int reset_left = 5;

  logic [num_channels_lp-1:0] v = '0;
  dram_req_s [num_channels_lp-1:0] req = '0;
  logic [num_channels_lp-1:0] data_v = '0;
  data_t [num_channels_lp-1:0] data = '0;
  logic [num_channels_lp-1:0] yumi;
  logic [num_channels_lp-1:0] data_yumi;
  logic [num_channels_lp-1:0] rdata_v;
  data_t [num_channels_lp-1:0] rdata;

  int errors;
  int pending;
  int reads_done;
  int writes;

  logic [31:0] rng_state = 32'h5dd487b5;
  logic [num_channels_lp-1:0] busy = '0;
  logic [num_channels_lp-1:0] took = '0;
  int issued [num_channels_lp] = '{default: 0};
  int data_wait [num_channels_lp] = '{default: 0};
  logic finished = 1'b0;
  int cycles = 0;

  always #2 clk = ~clk;

  dram_model
    #(.num_channels_p(num_channels_lp)
      ,.queue_depth_p(queue_depth_lp)
      ,.lat_hit_p(lat_hit_lp)
      ,.lat_miss_p(lat_miss_lp))
  DUT
    (.clk_i(clk)
    ,.reset_i(reset)
    ,.v_i(v)
    ,.req_i(req)
    ,.yumi_o(yumi)
    ,.data_v_i(data_v)
    ,.data_i(data)
    ,.data_yumi_o(data_yumi)
    ,.data_v_o(rdata_v)
    ,.data_o(rdata)
  );

  dram_model_checker
    #(.num_channels_p(num_channels_lp)
      ,.queue_depth_p(queue_depth_lp)
      ,.lat_hit_p(lat_hit_lp)
      ,.lat_miss_p(lat_miss_lp))
  checker_inst
    (.clk_i(clk)
    ,.reset_i(reset)
    ,.v_i(v)
    ,.req_i(req)
    ,.wdata_v_i(data_v)
    ,.wdata_i(data)
    ,.yumi_i(yumi)
    ,.data_yumi_i(data_yumi)
    ,.rdata_v_i(rdata_v)
    ,.rdata_i(rdata)
    ,.error_count_o(errors)
    ,.pending_o(pending)
    ,.reads_o(reads_done)
    ,.writes_o(writes)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // acceptance seen at the rising edge, used at the next falling edge
  always @(posedge clk) begin
    took <= yumi;
  end

  task automatic step_channel(input int ch);
    logic [31:0] r;
    if (busy[ch] && took[ch]) begin
      busy[ch] = 1'b0;
      issued[ch]++;
      v[ch] = 1'b0;
      data_v[ch] = 1'b0;
    end
    if (busy[ch]) begin
      if (data_wait[ch] > 0) begin
        data_wait[ch]--;
        if (data_wait[ch] == 0) begin
          data_v[ch] = 1'b1;
        end
      end
      return;
    end
    if (issued[ch] >= reqs_per_ch_lp) begin
      return;
    end
    rng_state = lcg_next(rng_state);
    r = rng_state;
    // idle cycle
    if (r[31:30] == 2'b00) begin
      return;
    end
    busy[ch] = 1'b1;
    v[ch] = 1'b1;
    req[ch].write_not_read = r[29];
    // two rows, four banks, four columns
    req[ch].addr = {3'b000, r[28], r[27:26], 2'b00, r[25:24]};
    data_v[ch] = r[29] && (r[23:22] != 2'b00);
    data_wait[ch] = (r[29] && (r[23:22] == 2'b00)) ? int'(r[21:20]) + 1 : 0;
    rng_state = lcg_next(rng_state);
    data[ch] = rng_state;
  endtask

  always @(negedge clk) begin
    if (reset_left > 0) begin
      reset_left--;
      if (reset_left == 0) begin
        reset = 1'b0;
      end
    end else begin
      finished = (pending == 0) && (busy == '0);
      for (int ch = 0; ch < num_channels_lp; ch++) begin
        step_channel(ch);
        if (issued[ch] < reqs_per_ch_lp || busy[ch]) begin
          finished = 1'b0;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_lp) begin
      $display("timeout after %0d cycles with requests or reads still outstanding", cycles);
      $display("test failed");
      $finish;
    end
  end

  initial begin
    while (!finished) begin
      @(posedge clk);
    end
    // catch any late read data
    repeat (4) @(posedge clk);
    @(negedge clk);
    $display("errors=%0d reads_returned=%0d writes=%0d", errors, reads_done, writes);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: compile.f
verilog/dram_pkg.sv
verilog/dram_bank_timer.sv
verilog/dram_channel_store.sv
verilog/dram_model.sv
bench/dram_model_checker.sv
bench/dram_model_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the dram model testbench with verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f compile.f --top-module dram_model_tb -Mdir obj_dir -o sim_dram
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_dram > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" "$log"; then
  exit 1
fi
exit 0
